// File: hdl/input_port_counters.sv
// input queue statistics
// counts full, empty and read cycles per input queue and flags input stalls
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module input_port_counters
    import leaf_monitor_pkg::*;
#(
    parameter int NUM_IN_PORTS = `NUM_IN_PORTS
) (
    input  logic                    clk_user,
    input  logic                    reset_user,
    input  logic                    is_done_mode,
    input  logic [NUM_IN_PORTS-1:0] in_full,
    input  logic [NUM_IN_PORTS-1:0] in_empty,
    input  logic [NUM_IN_PORTS-1:0] in_read,
    output in_queue_cnt_t           in_cnt [NUM_IN_PORTS],
    output logic                    in_stall
);

    // the operator waits on its inputs whenever one of them runs dry
    assign in_stall = |in_empty;

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                in_cnt[i] <= '0;
            end
        end else if (!is_done_mode) begin // frozen once the operator is done
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (in_full[i]) begin
                    in_cnt[i].full <= in_cnt[i].full + 1;
                end
                if (in_empty[i]) begin
                    in_cnt[i].empty <= in_cnt[i].empty + 1;
                end
                if (in_read[i]) begin
                    in_cnt[i].read <= in_cnt[i].read + 1;
                end
            end
        end
    end

endmodule

// File: hdl/leaf_monitor_macros.svh
// leaf monitor constants
// widths, port counts and port numbering shared by the statistics leaf
`ifndef LEAF_MONITOR_MACROS_SVH
`define LEAF_MONITOR_MACROS_SVH

// counter and bus data width
`define PAYLOAD_BITS 32

// default queue counts per side
`define NUM_IN_PORTS  2
`define NUM_OUT_PORTS 2

// port numbering on the overlay
`define NUM_PORT_BITS       4
`define INPUT_PORT_MIN_NUM  2 // port number of input queue 0
`define OUTPUT_PORT_MIN_NUM 9 // port number of output queue 0

// outgoing bus
`define WB_ADR_BITS 8

// must hold a whole report: 3 * inputs + 2 * outputs + 1 words
`define REPORT_FIFO_DEPTH 16

`endif

// File: hdl/leaf_monitor_pkg.sv
// leaf monitor types
// counter kinds, reporter states and the structs passed between blocks
`include "leaf_monitor_macros.svh"

package leaf_monitor_pkg;

    // encoding is also the low two address bits on the bus
    typedef enum logic [1:0] {
        stall_cnt = 2'd0,
        read_cnt  = 2'd1,
        empty_cnt = 2'd2,
        full_cnt  = 2'd3
    } cnt_type_e;

    // one state per group of report words, in report order
    typedef enum logic [2:0] {
        idle,
        in_read,
        in_empty,
        in_full,
        out_full,
        out_empty,
        stall,
        finished
    } seq_state_e;

    typedef struct packed {
        logic [`NUM_PORT_BITS-1:0] self_port;
        cnt_type_e                 cnt_type;
        logic [`PAYLOAD_BITS-1:0]  value;
    } report_word_t;

    typedef struct packed {
        logic [`PAYLOAD_BITS-1:0] full;
        logic [`PAYLOAD_BITS-1:0] empty;
        logic [`PAYLOAD_BITS-1:0] read;
    } in_queue_cnt_t;

    typedef struct packed {
        logic [`PAYLOAD_BITS-1:0] full;
        logic [`PAYLOAD_BITS-1:0] empty;
    } out_queue_cnt_t;

endpackage

// File: hdl/leaf_monitor_top.sv
// statistics leaf top
// queue counters, report sequencer and Wishbone write master
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module leaf_monitor_top
    import leaf_monitor_pkg::*;
#(
    parameter int NUM_IN_PORTS  = `NUM_IN_PORTS,
    parameter int NUM_OUT_PORTS = `NUM_OUT_PORTS
) (
    input  logic                     clk_user,
    input  logic                     reset_user,
    input  logic                     is_done,
    input  logic                     is_done_mode,
    input  logic [NUM_IN_PORTS-1:0]  in_full,
    input  logic [NUM_IN_PORTS-1:0]  in_empty,
    input  logic [NUM_IN_PORTS-1:0]  in_read,
    input  logic [NUM_OUT_PORTS-1:0] out_full,
    input  logic [NUM_OUT_PORTS-1:0] out_empty,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`WB_ADR_BITS-1:0]  wb_adr,
    output logic [`PAYLOAD_BITS-1:0] wb_dat_w,
    input  logic                     wb_ack,
    output logic                     report_busy
);

    in_queue_cnt_t  in_cnt [NUM_IN_PORTS];
    out_queue_cnt_t out_cnt [NUM_OUT_PORTS];
    logic           in_stall;
    logic           out_stall;
    report_word_t   word;
    logic           word_valid;
    logic           sending;
    logic           pending;

    // busy from the first emitted word until the last write is acked
    assign report_busy = sending || pending;

    input_port_counters #(
        .NUM_IN_PORTS (NUM_IN_PORTS)
    ) u_in_cnt (
        .clk_user     (clk_user),
        .reset_user   (reset_user),
        .is_done_mode (is_done_mode),
        .in_full      (in_full),
        .in_empty     (in_empty),
        .in_read      (in_read),
        .in_cnt       (in_cnt),
        .in_stall     (in_stall)
    );

    output_port_counters #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) u_out_cnt (
        .clk_user     (clk_user),
        .reset_user   (reset_user),
        .is_done_mode (is_done_mode),
        .out_full     (out_full),
        .out_empty    (out_empty),
        .out_cnt      (out_cnt),
        .out_stall    (out_stall)
    );

    queue_cnt_reporter #(
        .NUM_IN_PORTS  (NUM_IN_PORTS),
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) u_reporter (
        .clk_user     (clk_user),
        .reset_user   (reset_user),
        .is_done      (is_done),
        .is_done_mode (is_done_mode),
        .in_cnt       (in_cnt),
        .out_cnt      (out_cnt),
        .in_stall     (in_stall),
        .out_stall    (out_stall),
        .word         (word),
        .word_valid   (word_valid),
        .sending      (sending)
    );

    report_wb_master u_wb_master (
        .clk_user   (clk_user),
        .reset_user (reset_user),
        .word       (word),
        .word_valid (word_valid),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .pending    (pending)
    );

endmodule

// File: hdl/output_port_counters.sv
// output queue statistics
// counts full and empty cycles per output queue and flags output stalls
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module output_port_counters
    import leaf_monitor_pkg::*;
#(
    parameter int NUM_OUT_PORTS = `NUM_OUT_PORTS
) (
    input  logic                     clk_user,
    input  logic                     reset_user,
    input  logic                     is_done_mode,
    input  logic [NUM_OUT_PORTS-1:0] out_full,
    input  logic [NUM_OUT_PORTS-1:0] out_empty,
    output out_queue_cnt_t           out_cnt [NUM_OUT_PORTS],
    output logic                     out_stall
);

    assign out_stall = |out_full; // blocked by a full output queue

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                out_cnt[i] <= '0;
            end
        end else if (!is_done_mode) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (out_full[i]) begin
                    out_cnt[i].full <= out_cnt[i].full + 1;
                end
                if (out_empty[i]) begin
                    out_cnt[i].empty <= out_cnt[i].empty + 1;
                end
            end
        end
    end

endmodule

// File: hdl/queue_cnt_reporter.sv
// queue counter reporter
// counts stall cycles, freezes all counters on done and emits one report
// word per cycle: input read, empty, full, output full, empty, then stall
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module queue_cnt_reporter
    import leaf_monitor_pkg::*;
#(
    parameter int NUM_IN_PORTS  = `NUM_IN_PORTS,
    parameter int NUM_OUT_PORTS = `NUM_OUT_PORTS
) (
    input  logic           clk_user,
    input  logic           reset_user,
    input  logic           is_done,
    input  logic           is_done_mode,
    input  in_queue_cnt_t  in_cnt [NUM_IN_PORTS],
    input  out_queue_cnt_t out_cnt [NUM_OUT_PORTS],
    input  logic           in_stall,
    input  logic           out_stall,
    output report_word_t   word,
    output logic           word_valid,
    output logic           sending
);

    localparam int IN_IDX_BITS  = (NUM_IN_PORTS > 1) ? $clog2(NUM_IN_PORTS) : 1;
    localparam int OUT_IDX_BITS = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    localparam logic [`NUM_PORT_BITS-1:0] IN_BASE  = `INPUT_PORT_MIN_NUM;
    localparam logic [`NUM_PORT_BITS-1:0] OUT_BASE = `OUTPUT_PORT_MIN_NUM;
    localparam logic [`NUM_PORT_BITS-1:0] IN_LAST  = `NUM_PORT_BITS'(NUM_IN_PORTS - 1);
    localparam logic [`NUM_PORT_BITS-1:0] OUT_LAST = `NUM_PORT_BITS'(NUM_OUT_PORTS - 1);

    seq_state_e                state;
    seq_state_e                emit_state;
    seq_state_e                next_state;
    logic [`NUM_PORT_BITS-1:0] idx;
    logic [`NUM_PORT_BITS-1:0] emit_idx;
    logic [`NUM_PORT_BITS-1:0] next_idx;
    logic [IN_IDX_BITS-1:0]    in_sel;
    logic [OUT_IDX_BITS-1:0]   out_sel;
    logic                      start;
    logic                      emit;
    logic                      idx_last;

    in_queue_cnt_t             in_snap [NUM_IN_PORTS];
    out_queue_cnt_t            out_snap [NUM_OUT_PORTS];
    logic [`PAYLOAD_BITS-1:0]  stall_count;
    logic [`PAYLOAD_BITS-1:0]  stall_snap;
    report_word_t              word_next;

    // the first word goes out on the done edge itself, before the snapshot
    // registers hold anything, so it is taken from the live counters
    assign start      = (state == idle) && is_done;
    assign emit       = start || ((state != idle) && (state != finished));
    assign emit_state = start ? in_read : state;
    assign emit_idx   = idx; // still zero while idle
    assign in_sel     = emit_idx[IN_IDX_BITS-1:0];
    assign out_sel    = emit_idx[OUT_IDX_BITS-1:0];

    always_comb begin
        word_next.self_port = '0; // stall word carries port 0
        word_next.cnt_type  = stall_cnt;
        word_next.value     = stall_snap;
        case (emit_state)
            in_read: begin
                word_next.self_port = IN_BASE + emit_idx;
                word_next.cnt_type  = read_cnt;
                word_next.value     = start ? in_cnt[in_sel].read : in_snap[in_sel].read;
            end
            in_empty: begin
                word_next.self_port = IN_BASE + emit_idx;
                word_next.cnt_type  = empty_cnt;
                word_next.value     = in_snap[in_sel].empty;
            end
            in_full: begin
                word_next.self_port = IN_BASE + emit_idx;
                word_next.cnt_type  = full_cnt;
                word_next.value     = in_snap[in_sel].full;
            end
            out_full: begin
                word_next.self_port = OUT_BASE + emit_idx;
                word_next.cnt_type  = full_cnt;
                word_next.value     = out_snap[out_sel].full;
            end
            out_empty: begin
                word_next.self_port = OUT_BASE + emit_idx;
                word_next.cnt_type  = empty_cnt;
                word_next.value     = out_snap[out_sel].empty;
            end
            default: ;
        endcase
    end

    // walk ports within a group, then move to the next group
    always_comb begin
        case (emit_state)
            in_read, in_empty, in_full: idx_last = (emit_idx == IN_LAST);
            out_full, out_empty:        idx_last = (emit_idx == OUT_LAST);
            default:                    idx_last = 1'b1;
        endcase
        next_state = emit_state;
        if (idx_last) begin
            case (emit_state)
                in_read:   next_state = in_empty;
                in_empty:  next_state = in_full;
                in_full:   next_state = out_full;
                out_full:  next_state = out_empty;
                out_empty: next_state = stall;
                stall:     next_state = finished;
                default:   next_state = emit_state;
            endcase
        end
        next_idx = idx_last ? '0 : emit_idx + 1;
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            state       <= idle;
            idx         <= '0;
            word_valid  <= 1'b0;
            sending     <= 1'b0;
            stall_count <= '0;
        end else begin
            if (!is_done_mode && (in_stall || out_stall)) begin
                stall_count <= stall_count + 1;
            end
            word_valid <= emit;
            if (emit) begin
                state <= next_state;
                idx   <= next_idx;
            end
            if (start) begin
                sending <= 1'b1;
            end else if (state == finished) begin
                sending <= 1'b0; // last word is already in the buffer by now
            end
        end
    end

    always_ff @(posedge clk_user) begin
        if (start) begin
            in_snap    <= in_cnt;
            out_snap   <= out_cnt;
            stall_snap <= stall_count;
        end
        if (emit) begin
            word <= word_next;
        end
    end

endmodule

// File: hdl/report_wb_master.sv
// report bus master
// buffers report words and writes each one out as a Wishbone classic
// single write, address built from port number and counter type
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module report_wb_master
    import leaf_monitor_pkg::*;
(
    input  logic                     clk_user,
    input  logic                     reset_user,
    input  report_word_t             word,
    input  logic                     word_valid,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`WB_ADR_BITS-1:0]  wb_adr,
    output logic [`PAYLOAD_BITS-1:0] wb_dat_w,
    input  logic                     wb_ack,
    output logic                     pending
);

    localparam int PTR_BITS = $clog2(`REPORT_FIFO_DEPTH);

    report_word_t        fifo_mem [`REPORT_FIFO_DEPTH];
    logic [PTR_BITS:0]   wr_ptr; // extra bit tells full from empty
    logic [PTR_BITS:0]   rd_ptr;
    logic                fifo_empty;
    report_word_t        head;
    logic                bus_active;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign head       = fifo_mem[rd_ptr[PTR_BITS-1:0]];
    assign pending    = !fifo_empty || bus_active;

    // head entry stays put until it is popped on ack, so the address and
    // data hold steady for the whole transfer
    assign wb_cyc   = bus_active;
    assign wb_stb   = bus_active;
    assign wb_we    = bus_active; // write only
    assign wb_adr   = `WB_ADR_BITS'({head.self_port, head.cnt_type});
    assign wb_dat_w = head.value;

    always_ff @(posedge clk_user) begin
        if (word_valid) begin
            fifo_mem[wr_ptr[PTR_BITS-1:0]] <= word;
        end
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            bus_active <= 1'b0;
        end else begin
            if (word_valid) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (!bus_active) begin
                if (!fifo_empty) begin
                    bus_active <= 1'b1; // open next write
                end
            end else if (wb_ack) begin
                bus_active <= 1'b0; // idle at least one cycle between writes
                rd_ptr     <= rd_ptr + 1;
            end
        end
    end

endmodule

// File: leaf_monitor_top.f
+incdir+hdl
hdl/leaf_monitor_pkg.sv
hdl/input_port_counters.sv
hdl/output_port_counters.sv
hdl/queue_cnt_reporter.sv
hdl/report_wb_master.sv
hdl/leaf_monitor_top.sv
verification/clk_gen.sv
verification/tb_leaf_monitor_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the leaf monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_leaf_monitor_top \
    -f leaf_monitor_top.f -o sim_leaf_monitor > build.log 2>&1 \
    && ./obj_dir/sim_leaf_monitor > sim.log 2>&1 \
    || { cat build.log; [ -f sim.log ] && cat sim.log; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// File: verification/clk_gen.sv
// testbench clock and reset source
// free running clock, synchronous reset held for a few cycles
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_user,
    output logic reset_user
);

    initial begin
        clk_user = 1'b0;
        forever #(PERIOD_NS / 2) clk_user = ~clk_user;
    end

    initial begin
        reset_user = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_user);
        reset_user <= 1'b0; // released on a rising edge like the other inputs
    end

endmodule

// File: verification/tb_leaf_monitor_top.sv
// testbench for the statistics leaf
// random queue flags, a counter model and a Wishbone slave with random waits
`timescale 1ns/1ps
`include "leaf_monitor_macros.svh"

module tb_leaf_monitor_top;

    localparam int NI              = `NUM_IN_PORTS;
    localparam int NO              = `NUM_OUT_PORTS;
    localparam int FLAG_BITS       = 3 * NI + 2 * NO;
    localparam int EXP_WORDS       = 3 * NI + 2 * NO + 1;
    localparam int RANDOM_CYCLES   = 200;
    localparam int FROZEN_CYCLES   = 12;
    localparam int QUIET_CYCLES    = 40;
    localparam int WATCHDOG_CYCLES = 400 + 10 * EXP_WORDS;

    logic                     clk_user;
    logic                     reset_user;
    logic                     is_done;
    logic                     is_done_mode;
    logic [NI-1:0]            in_full;
    logic [NI-1:0]            in_empty;
    logic [NI-1:0]            in_read;
    logic [NO-1:0]            out_full;
    logic [NO-1:0]            out_empty;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`WB_ADR_BITS-1:0]  wb_adr;
    logic [`PAYLOAD_BITS-1:0] wb_dat_w;
    logic                     wb_ack = 1'b0;
    logic                     report_busy;
    logic                     check_count = 1'b0;

    // reference counters
    logic [`PAYLOAD_BITS-1:0] m_in_full [NI];
    logic [`PAYLOAD_BITS-1:0] m_in_empty [NI];
    logic [`PAYLOAD_BITS-1:0] m_in_read [NI];
    logic [`PAYLOAD_BITS-1:0] m_out_full [NO];
    logic [`PAYLOAD_BITS-1:0] m_out_empty [NO];
    logic [`PAYLOAD_BITS-1:0] m_stall;

    logic [`WB_ADR_BITS-1:0]  exp_adr [EXP_WORDS];
    logic [`PAYLOAD_BITS-1:0] exp_dat [EXP_WORDS];
    logic [`WB_ADR_BITS-1:0]  prev_adr;
    logic [`PAYLOAD_BITS-1:0] prev_dat;
    logic [31:0]              stim_seed = 32'd95815;
    logic [31:0]              slave_seed = 32'd95815;
    int                       errors = 0;
    int                       n_writes = 0;
    int                       ack_wait = 0;
    bit                       xfer_open = 1'b0;
    bit                       prev_open = 1'b0;
    bit                       report_started = 1'b0;
    bit                       report_over = 1'b0;

    clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (
        .clk_user   (clk_user),
        .reset_user (reset_user)
    );

    leaf_monitor_top i_dut (
        .clk_user     (clk_user),
        .reset_user   (reset_user),
        .is_done      (is_done),
        .is_done_mode (is_done_mode),
        .in_full      (in_full),
        .in_empty     (in_empty),
        .in_read      (in_read),
        .out_full     (out_full),
        .out_empty    (out_empty),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .report_busy  (report_busy)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bus address is port number above the two counter type bits
    function automatic logic [`WB_ADR_BITS-1:0] port_adr(input int port, input int kind);
        return `WB_ADR_BITS'(port * 4 + kind);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            errors++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    // read 1, empty 2, full 3, stall 0 with port 0
    task automatic build_expected();
        int k;
        k = 0;
        for (int i = 0; i < NI; i++) begin
            exp_adr[k] = port_adr(`INPUT_PORT_MIN_NUM + i, 1);
            exp_dat[k] = m_in_read[i];
            k = k + 1;
        end
        for (int i = 0; i < NI; i++) begin
            exp_adr[k] = port_adr(`INPUT_PORT_MIN_NUM + i, 2);
            exp_dat[k] = m_in_empty[i];
            k = k + 1;
        end
        for (int i = 0; i < NI; i++) begin
            exp_adr[k] = port_adr(`INPUT_PORT_MIN_NUM + i, 3);
            exp_dat[k] = m_in_full[i];
            k = k + 1;
        end
        for (int i = 0; i < NO; i++) begin
            exp_adr[k] = port_adr(`OUTPUT_PORT_MIN_NUM + i, 3);
            exp_dat[k] = m_out_full[i];
            k = k + 1;
        end
        for (int i = 0; i < NO; i++) begin
            exp_adr[k] = port_adr(`OUTPUT_PORT_MIN_NUM + i, 2);
            exp_dat[k] = m_out_empty[i];
            k = k + 1;
        end
        exp_adr[k] = port_adr(0, 0);
        exp_dat[k] = m_stall;
    endtask

    task automatic record_write();
        if (n_writes >= EXP_WORDS) begin
            errors++;
            $display("Failure at %0t ns: extra write to address %h after the full report",
                     $time, wb_adr);
        end else begin
            check_value("wb_adr", 32'(wb_adr), 32'(exp_adr[n_writes]));
            check_value("wb_dat_w", wb_dat_w, exp_dat[n_writes]);
            check_true(wb_we, "write completed with wb_we low");
        end
        n_writes++;
        if (n_writes == EXP_WORDS) begin
            report_over = 1'b1;
        end
    endtask

    // model, protocol checks and slave all sample pre-edge values here
    always @(posedge clk_user) begin
        if (reset_user) begin
            for (int i = 0; i < NI; i++) begin
                m_in_full[i]  = '0;
                m_in_empty[i] = '0;
                m_in_read[i]  = '0;
            end
            for (int i = 0; i < NO; i++) begin
                m_out_full[i]  = '0;
                m_out_empty[i] = '0;
            end
            m_stall = '0;
        end else begin
            if (!is_done_mode) begin
                for (int i = 0; i < NI; i++) begin
                    m_in_full[i]  = m_in_full[i] + 32'(in_full[i]);
                    m_in_empty[i] = m_in_empty[i] + 32'(in_empty[i]);
                    m_in_read[i]  = m_in_read[i] + 32'(in_read[i]);
                end
                for (int i = 0; i < NO; i++) begin
                    m_out_full[i]  = m_out_full[i] + 32'(out_full[i]);
                    m_out_empty[i] = m_out_empty[i] + 32'(out_empty[i]);
                end
                if ((|in_empty) || (|out_full)) begin
                    m_stall = m_stall + 1;
                end
            end
            if (!report_started) begin
                check_true(!wb_cyc && !wb_stb && !wb_we && !report_busy,
                           "bus or report_busy active before the first done pulse");
            end
            check_value("wb_cyc", 32'(wb_cyc), 32'(wb_stb));
            if (prev_open) begin // write was open and not acked at the last edge
                check_true(wb_stb, "wb_stb dropped before ack");
                check_value("wb_adr", 32'(wb_adr), 32'(prev_adr));
                check_value("wb_dat_w", wb_dat_w, prev_dat);
            end
            if (report_over) begin
                check_true(!report_busy, "report_busy high after the last ack");
            end
            if (check_count) begin
                check_value("write count", 32'(n_writes), 32'(EXP_WORDS));
            end
            if (wb_ack) begin
                record_write();
                wb_ack    <= 1'b0;
                xfer_open = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!xfer_open) begin
                    slave_seed = lcg_next(slave_seed);
                    ack_wait   = int'(slave_seed[25:24]); // 0 to 3 wait cycles
                    xfer_open  = 1'b1;
                end
                if (ack_wait == 0) begin
                    wb_ack <= 1'b1;
                end else begin
                    ack_wait--;
                end
            end
            if (is_done && !report_started) begin
                build_expected();
                report_started = 1'b1;
            end
            prev_open = wb_stb && !wb_ack;
            prev_adr  = wb_adr;
            prev_dat  = wb_dat_w;
        end
    end

    task automatic drive_random(input int cycles);
        repeat (cycles) begin
            @(posedge clk_user);
            stim_seed = lcg_next(stim_seed);
            {in_full, in_empty, in_read, out_full, out_empty} <= stim_seed[31 -: FLAG_BITS];
        end
    endtask

    task automatic pulse_done();
        @(posedge clk_user);
        is_done <= 1'b1;
        @(posedge clk_user);
        is_done <= 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        @(negedge clk_user);
        while (report_busy !== level) @(negedge clk_user);
    endtask

    task automatic request_count_check();
        @(posedge clk_user);
        check_count <= 1'b1;
        @(posedge clk_user);
        check_count <= 1'b0;
        @(negedge clk_user);
    endtask

    initial begin
        is_done      = 1'b0;
        is_done_mode = 1'b0;
        in_full      = '0;
        in_empty     = '0;
        in_read      = '0;
        out_full     = '0;
        out_empty    = '0;
        @(negedge clk_user);
        while (reset_user) @(negedge clk_user);
        drive_random(RANDOM_CYCLES);
        @(posedge clk_user);
        is_done_mode <= 1'b1;
        drive_random(FROZEN_CYCLES); // flag activity that must not be counted
        pulse_done();
        wait_busy(1'b1);
        wait_busy(1'b0);
        request_count_check();
        pulse_done(); // ignored until the next reset
        repeat (QUIET_CYCLES) @(negedge clk_user);
        request_count_check();
        $display("run complete: %0d writes, %0d errors", n_writes, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_user);
        $display("timeout: run not finished after %0d cycles, %0d writes, %0d errors",
                 WATCHDOG_CYCLES, n_writes, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
